/* common/eth_cfg_pkg.sv */
package eth_cfg_pkg;

    // RAM sizes in bytes
    localparam int TX_RAM_DEPTH   = 256;  // payload pattern RAM
    localparam int CMD_RAM_DEPTH  = 64;   // received command RAM

    // transmit side
    localparam int TX_PAYLOAD_LEN = 16;   // payload bytes per frame
    localparam int SEND_PERIOD    = 64;   // clk_norm cycles between requests

    // receive side
    localparam int ACK_DELAY      = 128;  // cycles before a command is acked

endpackage

/* common/eth_frame_pkg.sv */
package eth_frame_pkg;

    typedef logic [7:0]  byte_t;  // stream and RAM data
    typedef logic [15:0] addr_t;  // RAM byte address
    typedef logic [15:0] len_t;   // byte count
    typedef logic [15:0] port_t;  // UDP port number

    // UDP header is src port, dst port, length, checksum
    localparam int    UDP_HDR_LEN = 8;

    // FPGA side port, source on tx and checked destination on rx
    localparam port_t FPGA_PORT   = 16'd8080;

    // host side port, destination on tx
    localparam port_t HOST_PORT   = 16'd8000;

endpackage

/* rtl/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram
    import eth_frame_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic  clk_norm,
    input  logic  wr_en_i,
    input  addr_t wr_addr_i,
    input  byte_t wr_data_i,
    input  addr_t rd_addr_i,
    output byte_t rd_data_o
);

    byte_t mem [DEPTH];

    always_ff @(posedge clk_norm) begin
        if (wr_en_i) begin
            mem[wr_addr_i[$clog2(DEPTH)-1:0]] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i[$clog2(DEPTH)-1:0]];  // one cycle read latency
    end

    // writers in other blocks must stay inside the array
    assert property (@(posedge clk_norm) wr_en_i |-> (wr_addr_i < DEPTH));

endmodule

/* rtl/payload_fill.sv */
`timescale 1ns/1ps

module payload_fill
    import eth_cfg_pkg::*, eth_frame_pkg::*;
(
    input  logic  clk_norm,
    input  logic  arst_n_i,
    output logic  wr_en_o,
    output addr_t wr_addr_o,
    output byte_t wr_data_o,
    output logic  fill_done_o
);

    assign wr_data_o = byte_t'(wr_addr_o + addr_t'(1));  // address a holds a+1

    always_ff @(posedge clk_norm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_en_o     <= 1'b0;
            wr_addr_o   <= '0;
            fill_done_o <= 1'b0;
        end else if (wr_en_o) begin
            if (wr_addr_o == addr_t'(TX_RAM_DEPTH - 1)) begin
                wr_en_o     <= 1'b0;  // last word written
                fill_done_o <= 1'b1;
            end else begin
                wr_addr_o <= wr_addr_o + addr_t'(1);
            end
        end else if (!fill_done_o) begin
            wr_en_o <= 1'b1;  // start the single pass
        end
    end

endmodule

/* rtl/send_scheduler.sv */
`timescale 1ns/1ps

module send_scheduler
    import eth_cfg_pkg::*, eth_frame_pkg::*;
(
    input  logic  clk_norm,
    input  logic  arst_n_i,
    input  logic  send_en_i,
    input  logic  fill_done_i,
    output logic  req_valid_o,
    input  logic  req_ready_i,
    output addr_t req_addr_o,
    output len_t  req_len_o
);

    len_t  cnt_q;    // period timer
    addr_t start_q;  // start address of the next frame

    assign req_addr_o = start_q;
    assign req_len_o  = len_t'(TX_PAYLOAD_LEN);

    always_ff @(posedge clk_norm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q       <= '0;
            start_q     <= '0;
            req_valid_o <= 1'b0;
        end else if (!send_en_i) begin
            cnt_q       <= '0;  // disabled, restart from address 0
            start_q     <= '0;
            req_valid_o <= 1'b0;
        end else if (req_valid_o) begin
            if (req_ready_i) begin
                req_valid_o <= 1'b0;
                start_q     <= start_q + addr_t'(1);
            end
        end else if (fill_done_i) begin
            if (cnt_q == len_t'(SEND_PERIOD - 1)) begin
                req_valid_o <= 1'b1;
                cnt_q       <= '0;
            end else begin
                cnt_q <= cnt_q + len_t'(1);
            end
        end
    end

    // framer may stall, the request must not move under it
    assert property (@(posedge clk_norm) disable iff (!arst_n_i)
        (req_valid_o && !req_ready_i && send_en_i) |=> $stable(req_addr_o));

endmodule

/* udp_tx/udp_tx_framer.sv */
`timescale 1ns/1ps

module udp_tx_framer
    import eth_frame_pkg::*;
(
    input  logic  clk_norm,
    input  logic  arst_n_i,
    input  logic  req_valid_i,
    output logic  req_ready_o,
    input  addr_t req_addr_i,
    input  len_t  req_len_i,
    output addr_t ram_rd_addr_o,
    input  byte_t ram_rd_data_i,
    output logic  tx_valid_o,
    input  logic  tx_ready_i,
    output byte_t tx_data_o,
    output logic  tx_last_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PAY} state_t;

    state_t      state_q;
    logic [63:0] hdr_word;
    logic [63:0] hdr_q;     // remaining header bytes, msb first
    len_t        len_q;     // payload length of this frame
    len_t        cnt_q;     // byte index within header or payload
    addr_t       ptr_q;     // address of next payload byte
    logic        out_free;  // output register can take a byte
    logic        load_pay;

    assign req_ready_o = (state_q == ST_IDLE);
    assign out_free    = !tx_valid_o || tx_ready_i;
    assign load_pay    = (state_q == ST_PAY) && out_free && (cnt_q != len_q);
    assign hdr_word    = {FPGA_PORT, HOST_PORT, len_t'(UDP_HDR_LEN) + req_len_i, 16'h0000};

    // prefetch: read data always holds mem[ptr_q]
    assign ram_rd_addr_o = load_pay ? ptr_q + addr_t'(1) : ptr_q;

    always_ff @(posedge clk_norm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            len_q      <= '0;
            ptr_q      <= '0;
            tx_valid_o <= 1'b0;
            tx_last_o  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        tx_valid_o <= 1'b1;  // header byte 0 goes out now
                        cnt_q      <= len_t'(1);
                        len_q      <= req_len_i;
                        ptr_q      <= req_addr_i;
                        state_q    <= ST_HDR;
                    end
                end
                ST_HDR: begin
                    if (out_free) begin
                        if (cnt_q == len_t'(UDP_HDR_LEN - 1)) begin
                            cnt_q   <= '0;
                            state_q <= ST_PAY;
                        end else begin
                            cnt_q <= cnt_q + len_t'(1);
                        end
                    end
                end
                ST_PAY: begin
                    if (load_pay) begin
                        tx_last_o <= (cnt_q == len_q - len_t'(1));
                        cnt_q     <= cnt_q + len_t'(1);
                        ptr_q     <= ptr_q + addr_t'(1);
                    end else if (out_free) begin
                        tx_valid_o <= 1'b0;  // last byte taken
                        tx_last_o  <= 1'b0;
                        state_q    <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_norm) begin
        if (req_valid_i && req_ready_o) begin
            tx_data_o <= hdr_word[63:56];
            hdr_q     <= {hdr_word[55:0], 8'h00};
        end else if ((state_q == ST_HDR) && out_free) begin
            tx_data_o <= hdr_q[63:56];
            hdr_q     <= {hdr_q[55:0], 8'h00};
        end else if (load_pay) begin
            tx_data_o <= ram_rd_data_i;
        end
    end

    assert property (@(posedge clk_norm) disable iff (!arst_n_i)
        (tx_valid_o && !tx_ready_i) |=>
            (tx_valid_o && $stable(tx_data_o) && $stable(tx_last_o)));

endmodule

/* udp_rx/udp_rx_parser.sv */
`timescale 1ns/1ps

module udp_rx_parser
    import eth_frame_pkg::*;
(
    input  logic  clk_norm,
    input  logic  arst_n_i,
    input  logic  rx_in_valid_i,
    output logic  rx_in_ready_o,
    input  byte_t rx_in_data_i,
    input  logic  rx_in_last_i,
    output logic  ram_wr_en_o,
    output addr_t ram_wr_addr_o,
    output byte_t ram_wr_data_o,
    output logic  rx_pending_o,
    output len_t  rx_len_o,
    input  logic  rx_ack_i
);

    len_t  hdr_cnt_q;  // header bytes seen, saturates at UDP_HDR_LEN
    len_t  pay_cnt_q;  // payload bytes seen
    port_t dst_port_q;
    logic  accept;
    logic  in_hdr;
    logic  port_ok;
    logic  frame_ok;

    assign rx_in_ready_o = !rx_pending_o;  // hold off input until acked
    assign accept        = rx_in_valid_i && rx_in_ready_o;
    assign in_hdr        = (hdr_cnt_q != len_t'(UDP_HDR_LEN));
    assign port_ok       = (dst_port_q == FPGA_PORT);
    // the last byte may complete the header but not fall short of it
    assign frame_ok      = port_ok && (hdr_cnt_q >= len_t'(UDP_HDR_LEN - 1));

    always_ff @(posedge clk_norm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hdr_cnt_q    <= '0;
            pay_cnt_q    <= '0;
            dst_port_q   <= '0;
            rx_pending_o <= 1'b0;
            rx_len_o     <= '0;
            ram_wr_en_o  <= 1'b0;
        end else begin
            ram_wr_en_o <= accept && !in_hdr && port_ok;
            if (rx_ack_i) begin
                rx_pending_o <= 1'b0;
            end
            if (accept) begin
                if (in_hdr) begin
                    hdr_cnt_q <= hdr_cnt_q + len_t'(1);
                    if (hdr_cnt_q == len_t'(2)) dst_port_q[15:8] <= rx_in_data_i;
                    if (hdr_cnt_q == len_t'(3)) dst_port_q[7:0]  <= rx_in_data_i;
                end else begin
                    pay_cnt_q <= pay_cnt_q + len_t'(1);
                end
                if (rx_in_last_i) begin
                    hdr_cnt_q <= '0;  // ready for next frame
                    pay_cnt_q <= '0;
                    if (frame_ok) begin
                        rx_pending_o <= 1'b1;
                        rx_len_o     <= in_hdr ? pay_cnt_q : pay_cnt_q + len_t'(1);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_norm) begin
        ram_wr_addr_o <= addr_t'(pay_cnt_q);  // payload lands from address 0
        ram_wr_data_o <= rx_in_data_i;
    end

    // a waiting command keeps the input held off until its ack
    assert property (@(posedge clk_norm) disable iff (!arst_n_i)
        (rx_pending_o && !rx_ack_i) |=> !rx_in_ready_o);

endmodule

/* rtl/cmd_ack_ctrl.sv */
`timescale 1ns/1ps

module cmd_ack_ctrl
    import eth_cfg_pkg::*;
(
    input  logic clk_norm,
    input  logic arst_n_i,
    input  logic rx_pending_i,
    output logic rx_ack_o
);

    typedef enum logic [1:0] {ST_WAIT, ST_DELAY, ST_ACK, ST_RELEASE} state_t;

    state_t                         state_q;
    logic [$clog2(ACK_DELAY)-1:0]   cnt_q;

    always_ff @(posedge clk_norm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= ST_WAIT;
            cnt_q    <= '0;
            rx_ack_o <= 1'b0;
        end else begin
            case (state_q)
                ST_WAIT: begin
                    cnt_q <= '0;
                    if (rx_pending_i) state_q <= ST_DELAY;
                end
                ST_DELAY: begin
                    cnt_q <= cnt_q + 1'b1;
                    // wait state already used one cycle of the delay
                    if (cnt_q == ($clog2(ACK_DELAY))'(ACK_DELAY - 2)) begin
                        rx_ack_o <= 1'b1;
                        state_q  <= ST_ACK;
                    end
                end
                ST_ACK: state_q <= ST_RELEASE;  // give pending a cycle to drop
                ST_RELEASE: begin
                    if (!rx_pending_i) begin
                        rx_ack_o <= 1'b0;
                        state_q  <= ST_WAIT;
                    end
                end
                default: state_q <= ST_WAIT;
            endcase
        end
    end

endmodule

/* rtl/udp_stream_top.sv */
`timescale 1ns/1ps

module udp_stream_top
    import eth_cfg_pkg::*, eth_frame_pkg::*;
(
    input  logic  clk_norm,
    input  logic  arst_n_i,
    input  logic  send_en_i,
    output logic  tx_valid_o,
    input  logic  tx_ready_i,
    output byte_t tx_data_o,
    output logic  tx_last_o,
    input  logic  rx_in_valid_i,
    output logic  rx_in_ready_o,
    input  byte_t rx_in_data_i,
    input  logic  rx_in_last_i,
    output logic  rx_pending_o,
    output len_t  rx_len_o,
    input  addr_t cmd_rd_addr_i,
    output byte_t cmd_rd_data_o
);

    logic  fill_wr_en;   // payload RAM write side
    addr_t fill_wr_addr;
    byte_t fill_wr_data;
    logic  fill_done;
    logic  req_valid;    // scheduler to framer
    logic  req_ready;
    addr_t req_addr;
    len_t  req_len;
    addr_t tx_rd_addr;
    byte_t tx_rd_data;
    logic  cmd_wr_en;    // parser to command RAM
    addr_t cmd_wr_addr;
    byte_t cmd_wr_data;
    logic  rx_ack;

    payload_fill i_payload_fill (
        .clk_norm, .arst_n_i, .wr_en_o(fill_wr_en), .wr_addr_o(fill_wr_addr),
        .wr_data_o(fill_wr_data), .fill_done_o(fill_done)
    );

    byte_ram #(.DEPTH(TX_RAM_DEPTH)) i_payload_ram (
        .clk_norm, .wr_en_i(fill_wr_en), .wr_addr_i(fill_wr_addr), .wr_data_i(fill_wr_data),
        .rd_addr_i(tx_rd_addr), .rd_data_o(tx_rd_data)
    );

    send_scheduler i_send_scheduler (
        .clk_norm, .arst_n_i, .send_en_i, .fill_done_i(fill_done), .req_valid_o(req_valid),
        .req_ready_i(req_ready), .req_addr_o(req_addr), .req_len_o(req_len)
    );

    udp_tx_framer i_udp_tx_framer (
        .clk_norm, .arst_n_i, .req_valid_i(req_valid), .req_ready_o(req_ready),
        .req_addr_i(req_addr), .req_len_i(req_len), .ram_rd_addr_o(tx_rd_addr),
        .ram_rd_data_i(tx_rd_data), .tx_valid_o, .tx_ready_i, .tx_data_o, .tx_last_o
    );

    udp_rx_parser i_udp_rx_parser (
        .clk_norm, .arst_n_i, .rx_in_valid_i, .rx_in_ready_o, .rx_in_data_i, .rx_in_last_i,
        .ram_wr_en_o(cmd_wr_en), .ram_wr_addr_o(cmd_wr_addr), .ram_wr_data_o(cmd_wr_data),
        .rx_pending_o, .rx_len_o, .rx_ack_i(rx_ack)
    );

    byte_ram #(.DEPTH(CMD_RAM_DEPTH)) i_cmd_ram (
        .clk_norm, .wr_en_i(cmd_wr_en), .wr_addr_i(cmd_wr_addr), .wr_data_i(cmd_wr_data),
        .rd_addr_i(cmd_rd_addr_i), .rd_data_o(cmd_rd_data_o)
    );

    cmd_ack_ctrl i_cmd_ack_ctrl (
        .clk_norm, .arst_n_i, .rx_pending_i(rx_pending_o), .rx_ack_o(rx_ack)
    );

endmodule

/* verif/udp_stream_tb.sv */
`timescale 1ns/1ps

module udp_stream_tb
    import eth_cfg_pkg::*, eth_frame_pkg::*;
();

    typedef enum {K_TX, K_DIS, K_RX, K_RX_SHORT} kind_e;

    typedef struct {
        kind_e kind;
        port_t port;        // destination port of rx frames
        len_t  len;         // payload bytes
        bit    bp;          // random tx back-pressure
        int    expect_val;  // frame number on tx, pending on rx
    } test_row_t;

    localparam int N_ROWS = 11;

    logic  clk_norm;
    logic  arst_n_i;
    logic  send_en_i;
    logic  tx_valid_o;
    logic  tx_ready_i;
    byte_t tx_data_o;
    logic  tx_last_o;
    logic  rx_in_valid_i;
    logic  rx_in_ready_o;
    byte_t rx_in_data_i;
    logic  rx_in_last_i;
    logic  rx_pending_o;
    len_t  rx_len_o;
    addr_t cmd_rd_addr_i;
    byte_t cmd_rd_data_o;

    test_row_t rows [N_ROWS];
    byte_t     sent [CMD_RAM_DEPTH];  // payload of the current rx frame
    int        seed;
    int        errors;
    int        cycle_cnt;
    int        cycle_limit;

    udp_stream_top i_udp_stream_top (.*);

    initial begin
        clk_norm = 1'b0;
        forever #4 clk_norm = ~clk_norm;
    end

    always @(posedge clk_norm) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_byte(input byte_t got, input byte_t exp, input string sig);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input len_t got, input len_t exp, input string sig);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_port(input port_t got, input port_t exp, input string sig);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string sig);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, sig, got, exp);
            errors++;
        end
    endtask

    // collects one tx frame, a handshake is seen at the negedge before its edge
    task automatic receive_frame(input int k, input len_t n_pay, input bit bp);
        byte_t       hdr [UDP_HDR_LEN];
        int          n_all;
        int          idx;
        logic [31:0] r;
        n_all = UDP_HDR_LEN + int'(n_pay);
        idx   = 0;
        while (idx < n_all) begin
            @(posedge clk_norm);
            #1;
            r          = $random(seed);
            tx_ready_i = bp ? (r[0] | r[1]) : 1'b1;  // about 3 of 4 cycles ready
            @(negedge clk_norm);
            if (tx_valid_o && tx_ready_i) begin
                if (idx < UDP_HDR_LEN) begin
                    hdr[idx] = tx_data_o;
                end else begin
                    check_byte(tx_data_o, byte_t'(k + idx - UDP_HDR_LEN + 1),
                               $sformatf("tx_data_o[%0d]", idx));
                end
                check_flag(tx_last_o, idx == n_all - 1, $sformatf("tx_last_o[%0d]", idx));
                idx++;
            end
        end
        check_port({hdr[0], hdr[1]}, FPGA_PORT, "tx source port");
        check_port({hdr[2], hdr[3]}, HOST_PORT, "tx destination port");
        check_len({hdr[4], hdr[5]}, len_t'(UDP_HDR_LEN) + n_pay, "tx udp length");
        check_byte(hdr[6], 8'h00, "tx checksum high");
        check_byte(hdr[7], 8'h00, "tx checksum low");
    endtask

    task automatic push_rx_byte(input byte_t data, input logic last);
        @(posedge clk_norm);
        #1;
        rx_in_valid_i = 1'b1;
        rx_in_data_i  = data;
        rx_in_last_i  = last;
        @(negedge clk_norm);
        while (!rx_in_ready_o) begin
            @(negedge clk_norm);
        end
    endtask

    task automatic send_rx_frame(input port_t dst, input len_t n_pay, input int n_hdr);
        byte_t hdr [UDP_HDR_LEN];
        len_t  ulen;
        int    n_all;
        ulen  = len_t'(UDP_HDR_LEN) + n_pay;
        hdr   = '{HOST_PORT[15:8], HOST_PORT[7:0], dst[15:8], dst[7:0],
                  ulen[15:8], ulen[7:0], 8'h00, 8'h00};
        n_all = n_hdr + int'(n_pay);
        for (int i = 0; i < n_all; i++) begin
            if (i < n_hdr) begin
                push_rx_byte(hdr[i], i == n_all - 1);
            end else begin
                push_rx_byte(sent[i - n_hdr], i == n_all - 1);
            end
        end
        @(posedge clk_norm);
        #1;
        rx_in_valid_i = 1'b0;
        rx_in_last_i  = 1'b0;
    endtask

    task automatic run_row(input test_row_t row);
        int cnt;
        case (row.kind)
            K_TX: receive_frame(row.expect_val, row.len, row.bp);
            K_DIS: begin
                @(posedge clk_norm);
                #1;
                send_en_i  = 1'b0;
                tx_ready_i = 1'b1;
                repeat (SEND_PERIOD + UDP_HDR_LEN + TX_PAYLOAD_LEN + 16) begin
                    @(negedge clk_norm);
                    check_flag(tx_valid_o, 1'b0, "tx_valid_o while disabled");
                end
                @(posedge clk_norm);
                #1;
                send_en_i = 1'b1;
                receive_frame(row.expect_val, row.len, row.bp);
                @(posedge clk_norm);
                #1;
                send_en_i = 1'b0;  // tx stays quiet during rx rows
            end
            default: begin
                for (int i = 0; i < int'(row.len); i++) begin
                    sent[i] = byte_t'($random(seed));
                end
                send_rx_frame(row.port, row.len, (row.kind == K_RX_SHORT) ? 5 : UDP_HDR_LEN);
                @(negedge clk_norm);
                check_flag(rx_pending_o, row.expect_val != 0, "rx_pending_o");
                if (row.expect_val != 0) begin
                    check_len(rx_len_o, row.len, "rx_len_o");
                    cnt = 0;
                    while (rx_pending_o) begin
                        check_flag(rx_in_ready_o, 1'b0, "rx_in_ready_o while pending");
                        cnt++;
                        @(negedge clk_norm);
                    end
                    check_len(len_t'(cnt), len_t'(ACK_DELAY + 1), "rx_pending_o cycles");
                    for (int i = 0; i < int'(row.len); i++) begin
                        @(posedge clk_norm);
                        #1;
                        cmd_rd_addr_i = addr_t'(i);
                        @(posedge clk_norm);  // registered read
                        @(negedge clk_norm);
                        check_byte(cmd_rd_data_o, sent[i], $sformatf("cmd_rd_data_o[%0d]", i));
                    end
                end else begin
                    repeat (8) begin
                        check_flag(rx_pending_o, 1'b0, "rx_pending_o after drop");
                        check_flag(rx_in_ready_o, 1'b1, "rx_in_ready_o after drop");
                        @(negedge clk_norm);
                    end
                end
            end
        endcase
    endtask

    initial begin
        int n_frames;
        int n_rx;
        int n_ok;
        int errs_before;
        seed          = 32'hd6e0a6f9;
        errors        = 0;
        cycle_cnt     = 0;
        cycle_limit   = 0;
        n_frames      = 0;
        n_rx          = 0;
        n_ok          = 0;
        arst_n_i      = 1'b0;
        send_en_i     = 1'b1;
        tx_ready_i    = 1'b1;
        rx_in_valid_i = 1'b0;
        rx_in_data_i  = '0;
        rx_in_last_i  = 1'b0;
        cmd_rd_addr_i = '0;
        rows = '{
            '{K_TX,       FPGA_PORT, len_t'(TX_PAYLOAD_LEN), 1'b0, 0},
            '{K_TX,       FPGA_PORT, len_t'(TX_PAYLOAD_LEN), 1'b0, 1},
            '{K_TX,       FPGA_PORT, len_t'(TX_PAYLOAD_LEN), 1'b0, 2},
            '{K_TX,       FPGA_PORT, len_t'(TX_PAYLOAD_LEN), 1'b0, 3},
            '{K_TX,       FPGA_PORT, len_t'(TX_PAYLOAD_LEN), 1'b1, 4},
            '{K_TX,       FPGA_PORT, len_t'(TX_PAYLOAD_LEN), 1'b1, 5},
            '{K_DIS,      FPGA_PORT, len_t'(TX_PAYLOAD_LEN), 1'b0, 0},  // restarts at 0
            '{K_RX,       FPGA_PORT, len_t'(10),             1'b0, 1},
            '{K_RX,       16'd9999,  len_t'(10),             1'b0, 0},  // foreign port
            '{K_RX_SHORT, FPGA_PORT, len_t'(0),              1'b0, 0},
            '{K_RX,       FPGA_PORT, len_t'(7),              1'b0, 1}
        };
        foreach (rows[t]) begin
            if (rows[t].kind == K_TX || rows[t].kind == K_DIS) begin
                n_frames++;
            end else begin
                n_rx++;
            end
        end
        cycle_limit = 2 * (TX_RAM_DEPTH
                    + n_frames * (SEND_PERIOD + TX_PAYLOAD_LEN + UDP_HDR_LEN)
                    + n_rx * (ACK_DELAY + 64));
        repeat (3) @(posedge clk_norm);
        #1;
        arst_n_i = 1'b1;
        for (int t = 0; t < N_ROWS; t++) begin
            errs_before = errors;
            run_row(rows[t]);
            if (errors == errs_before) begin
                n_ok++;
                $display("test %0d %s: ok", t, rows[t].kind.name());
            end else begin
                $display("test %0d %s: %0d errors", t, rows[t].kind.name(), errors - errs_before);
            end
        end
        $display("summary: %0d of %0d tests ok, %0d mismatches", n_ok, N_ROWS, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* udp_stream_top.f */
common/eth_cfg_pkg.sv
common/eth_frame_pkg.sv
rtl/byte_ram.sv
rtl/payload_fill.sv
rtl/send_scheduler.sv
udp_tx/udp_tx_framer.sv
udp_rx/udp_rx_parser.sv
rtl/cmd_ack_ctrl.sv
rtl/udp_stream_top.sv
verif/udp_stream_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= udp_stream_tb
FILELIST  ?= udp_stream_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "tests failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qx "all tests passed" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
